//--- Makefile
# Verilator build and run of the spectrum display testbench
VERILATOR ?= verilator
TOP ?= spectrumDisplay_tb
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- dv/spectrumDisplay_asserts.sv
// concurrent checks on the pixel port and frame state, bound into the top level
`timescale 1ns/1ps

module spectrumDisplay_asserts (
	input logic clk,
	input logic resetn,
	input logic plot,
	input displayPkg::xCoord x,
	input displayPkg::yCoord y,
	input displayPkg::frameState currentState
);

	// no pixel leaves while idle
	noPlotInIdle: assert property (@(posedge clk) disable iff (resetn)
		plot |-> (currentState != displayPkg::stIdle))
		else $error("plot high while idle");

	// idle only goes to clear
	idleStep: assert property (@(posedge clk) disable iff (resetn)
		(currentState == displayPkg::stIdle) |=>
		(currentState == displayPkg::stIdle || currentState == displayPkg::stClear))
		else $error("illegal transition out of idle");

	// clear only goes to graph
	clearStep: assert property (@(posedge clk) disable iff (resetn)
		(currentState == displayPkg::stClear) |=>
		(currentState == displayPkg::stClear || currentState == displayPkg::stGraph))
		else $error("illegal transition out of clear");

	// graph only goes back to idle
	graphStep: assert property (@(posedge clk) disable iff (resetn)
		(currentState == displayPkg::stGraph) |=>
		(currentState == displayPkg::stGraph || currentState == displayPkg::stIdle))
		else $error("illegal transition out of graph");

	// pixel inside the visible area
	onScreen: assert property (@(posedge clk) disable iff (resetn)
		plot |-> (x < displayPkg::xCoord'(displayPkg::screenWidth)
			&& y < displayPkg::yCoord'(displayPkg::screenHeight)))
		else $error("pixel outside the screen");

endmodule

bind spectrumDisplay spectrumDisplay_asserts frameChecks (
	.clk(clk),
	.resetn(resetn),
	.plot(plot),
	.x(x),
	.y(y),
	.currentState(currentState)
);

//--- dv/spectrumDisplay_tb.sv
// random level writes in idle checked against a pixel model of the note bar graph
`timescale 1ns/1ps

module spectrumDisplay_tb;

	localparam int tickDivide = 4;
	localparam int ticksPerFrame = 80;
	// cycles from one frame start to the next
	localparam int framePeriod = tickDivide * ticksPerFrame;
	// longest frame is 76800 clear plus 13x216x11 bar pixels
	localparam int frameBudget = 120000;
	localparam int timeoutCycles = 4 * frameBudget;

	logic clk;
	logic resetn;
	logic levelWe;
	notePkg::noteT levelNote;
	notePkg::levelT levelValue;
	logic plot;
	displayPkg::xCoord x;
	displayPkg::yCoord y;
	displayPkg::colourT colour;
	displayPkg::frameState currentState;

	// mirror of the level bank
	notePkg::levelT modelLevels [notePkg::noteCount];
	// edges since reset release
	int edgeCount;
	int timeoutCount = 0;

	spectrumDisplay #(
		.tickDivide(tickDivide),
		.ticksPerFrame(ticksPerFrame)
	) UUT (
		.clk(clk),
		.resetn(resetn),
		.levelWe(levelWe),
		.levelNote(levelNote),
		.levelValue(levelValue),
		.plot(plot),
		.x(x),
		.y(y),
		.colour(colour),
		.currentState(currentState)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// hard stop if a frame never ends
	always @(posedge clk) begin
		timeoutCount <= timeoutCount + 1;
		if (timeoutCount >= timeoutCycles) begin
			$display("timeout after %0d cycles, the frames did not complete", timeoutCount);
			$display("Test failures found");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic reportFailure(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "check failed");
	endtask

	task automatic checkCoord(input displayPkg::xCoord gotX, input displayPkg::yCoord gotY,
		input displayPkg::xCoord expX, input displayPkg::yCoord expY);
		if (gotX !== expX || gotY !== expY)
			reportFailure($sformatf("pixel at (%0d,%0d), expected (%0d,%0d)",
				gotX, gotY, expX, expY));
	endtask

	task automatic checkColour(input displayPkg::colourT got, input displayPkg::colourT exp);
		if (got !== exp)
			reportFailure($sformatf("colour %b, expected %b", got, exp));
	endtask

	task automatic checkState(input displayPkg::frameState got,
		input displayPkg::frameState exp);
		if (got !== exp)
			reportFailure($sformatf("state %s, expected %s", got.name(), exp.name()));
	endtask

	task automatic checkPlot(input logic got, input logic exp);
		if (got !== exp)
			reportFailure($sformatf("plot %b, expected %b", got, exp));
	endtask

	// one clock, then mirror any write the bank took on that edge
	task automatic stepCycle();
		@(posedge clk);
		if (levelWe && int'(levelNote) < notePkg::noteCount)
			modelLevels[int'(levelNote)] = levelValue;
		#1;
		edgeCount++;
	endtask

	// mix of overflow, clamped, zero and plain magnitudes
	function automatic notePkg::levelT randomLevel();
		int kind;
		kind = $urandom_range(0, 4);
		case (kind)
			0: return {4'($urandom_range(1, 15)), 8'($urandom)};
			1: return {4'h0, 8'($urandom_range(213, 255))};
			2: return '0;
			default: return {4'h0, 8'($urandom)};
		endcase
	endfunction

	// full top on overflow, else floor minus magnitude, clamped
	function automatic displayPkg::yCoord topRowFor(input notePkg::levelT lvl);
		int top;
		if (lvl[11:8] != 4'h0)
			top = notePkg::fullBarTop;
		else
			top = notePkg::barFloor - int'(lvl[7:0]);
		if (top < notePkg::fullBarTop)
			top = notePkg::fullBarTop;
		return displayPkg::yCoord'(top);
	endfunction

	function automatic displayPkg::colourT colourFor(input notePkg::levelT lvl);
		return (lvl[11:8] != 4'h0) ? displayPkg::colRed : displayPkg::colWhite;
	endfunction

	// random writes in the idle gap, illegal note codes included, until plot rises
	task automatic idleUntilFrame();
		while (plot !== 1'b1) begin
			checkState(currentState, displayPkg::stIdle);
			levelWe = 1'($urandom_range(0, 1));
			levelNote = notePkg::noteT'(4'($urandom_range(0, 15)));
			levelValue = randomLevel();
			stepCycle();
		end
		levelWe = 1'b0;
		// frame starts land every framePeriod from the first edge, plot 1 edge later
		if ((edgeCount - 2) % framePeriod != 0)
			reportFailure($sformatf("plot rose at cycle %0d, not 2 after a frame start",
				edgeCount));
	endtask

	// whole screen in raster order, black, back to back
	task automatic sweepClear();
		for (int row = 0; row < displayPkg::screenHeight; row++) begin
			for (int col = 0; col < displayPkg::screenWidth; col++) begin
				checkPlot(plot, 1'b1);
				checkState(currentState, displayPkg::stClear);
				checkCoord(x, y, displayPkg::xCoord'(col), displayPkg::yCoord'(row));
				checkColour(colour, displayPkg::colBlack);
				stepCycle();
			end
		end
	endtask

	// every bar row by row, top row to barBottom, columns left to right
	task automatic traceBars();
		int left;
		displayPkg::yCoord top;
		displayPkg::colourT barCol;
		for (int n = 0; n < notePkg::noteCount; n++) begin
			left = notePkg::barBaseX + n * notePkg::barPitch;
			top = topRowFor(modelLevels[n]);
			barCol = colourFor(modelLevels[n]);
			for (int row = int'(top); row <= notePkg::barBottom; row++) begin
				for (int col = left; col < left + notePkg::barWidth; col++) begin
					checkPlot(plot, 1'b1);
					checkState(currentState, displayPkg::stGraph);
					checkCoord(x, y, displayPkg::xCoord'(col), displayPkg::yCoord'(row));
					checkColour(colour, barCol);
					stepCycle();
				end
			end
		end
		// back in idle one cycle after the last bar pixel
		checkPlot(plot, 1'b0);
		checkState(currentState, displayPkg::stIdle);
	endtask

	initial begin
		void'($urandom(31648));
		clk = 1'b0;
		resetn = 1'b1;
		levelWe = 1'b0;
		levelNote = notePkg::noteA4;
		levelValue = '0;
		edgeCount = 0;
		for (int i = 0; i < notePkg::noteCount; i++)
			modelLevels[i] = '0;
		// reset for 4 edges, released just after the last
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b0;
		checkPlot(plot, 1'b0);
		checkState(currentState, displayPkg::stIdle);
		for (int frame = 0; frame < 3; frame++) begin
			idleUntilFrame();
			sweepClear();
			traceBars();
		end
		// plot stays low until the following frame start
		idleUntilFrame();
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- rtl/barPlotter.sv
// bar graph datapath, walks every pixel of the thirteen note bars and colours them by level
`timescale 1ns/1ps

module barPlotter (
	input logic clk,
	input logic resetn,
	input logic runGraph,
	input notePkg::levelT readLevel,
	output notePkg::noteT readNote,
	output logic barValid,
	output logic barLast,
	output displayPkg::xCoord barX,
	output displayPkg::yCoord barY,
	output displayPkg::colourT barColour
);

	// tallest magnitude before the top hits the clamp
	localparam logic [7:0] maxMag = 8'(notePkg::barFloor - notePkg::fullBarTop);

	logic [3:0] noteIdx;
	logic [3:0] colCnt;
	// offset below the bar top
	displayPkg::yCoord rowOff;
	notePkg::levelT heldLevel;
	notePkg::levelT useLevel;
	displayPkg::yCoord barTop;
	logic firstPixel;
	logic overflow;
	logic lastCol;
	logic lastRow;
	logic lastNote;

	assign readNote = notePkg::noteT'(noteIdx);

	// top left pixel of a bar, level comes straight from the bank
	assign firstPixel = (colCnt == '0) && (rowOff == '0);
	assign useLevel = firstPixel ? readLevel : heldLevel;
	assign overflow = (useLevel[11:8] != 4'd0);

	// top row from level
	always_comb begin
		if (overflow)
			barTop = displayPkg::yCoord'(notePkg::fullBarTop);
		else if (useLevel[7:0] > maxMag)
			barTop = displayPkg::yCoord'(notePkg::fullBarTop);
		else
			barTop = displayPkg::yCoord'(notePkg::barFloor) - useLevel[7:0];
	end

	assign lastCol = (colCnt == 4'(notePkg::barWidth - 1));
	assign lastRow = (barY == displayPkg::yCoord'(notePkg::barBottom));
	assign lastNote = (noteIdx == 4'(notePkg::noteCount - 1));

	// note, row, column counters
	always_ff @(posedge clk) begin
		if (resetn) begin
			noteIdx <= '0;
			colCnt <= '0;
			rowOff <= '0;
		end else if (runGraph) begin
			if (!lastCol) begin
				colCnt <= colCnt + 1'b1;
			end else begin
				colCnt <= '0;
				if (!lastRow) begin
					rowOff <= rowOff + 1'b1;
				end else begin
					// bar done, on to the next note
					rowOff <= '0;
					noteIdx <= lastNote ? '0 : noteIdx + 1'b1;
				end
			end
		end
	end

	// latch on the bar's first pixel, held for the rest of the bar
	always_ff @(posedge clk) begin
		if (runGraph && firstPixel)
			heldLevel <= readLevel;
	end

	// pixel position
	assign barX = displayPkg::xCoord'(notePkg::barBaseX)
		+ displayPkg::xCoord'(noteIdx) * displayPkg::xCoord'(notePkg::barPitch)
		+ displayPkg::xCoord'(colCnt);
	assign barY = barTop + rowOff;

	assign barColour = overflow ? displayPkg::colRed : displayPkg::colWhite;
	assign barValid = runGraph;
	// last column, bottom row of A5
	assign barLast = runGraph && lastNote && lastCol && lastRow;

endmodule

//--- rtl/displayPkg.sv
// display geometry, colour codes and frame states shared by control and the pixel datapaths
package displayPkg;

	// visible screen size in pixels
	localparam int screenWidth = 320;
	localparam int screenHeight = 240;

	// column needs 9 bits for 0..319
	typedef logic [8:0] xCoord;
	// row fits in 8 bits for 0..239
	typedef logic [7:0] yCoord;

	// one bit per channel, red in the msb
	typedef logic [2:0] colourT;

	localparam colourT colBlack = 3'b000;
	localparam colourT colWhite = 3'b111;
	// overflow marker
	localparam colourT colRed = 3'b100;

	// frame sequence
	// idle waits for a frame start, clear blanks the screen, graph draws the bars
	typedef enum logic [1:0] {
		stIdle,
		stClear,
		stGraph
	} frameState;

endpackage

//--- rtl/frameControl.sv
// frame FSM, runs clear then graph per frame start and registers the selected pixel out
`timescale 1ns/1ps

module frameControl (
	input logic clk,
	input logic resetn,
	input logic frameStart,
	input logic clearValid,
	input logic clearLast,
	input logic barValid,
	input logic barLast,
	input displayPkg::xCoord clearX,
	input displayPkg::xCoord barX,
	input displayPkg::yCoord clearY,
	input displayPkg::yCoord barY,
	input displayPkg::colourT barColour,
	output logic runClear,
	output logic runGraph,
	output logic plot,
	output displayPkg::xCoord x,
	output displayPkg::yCoord y,
	output displayPkg::colourT colour,
	output displayPkg::frameState currentState
);

	displayPkg::frameState state;
	displayPkg::frameState nextState;

	// next state
	// frame starts only count in idle
	always_comb begin
		nextState = state;
		case (state)
			displayPkg::stIdle:
				if (frameStart)
					nextState = displayPkg::stClear;
			displayPkg::stClear:
				if (clearLast)
					nextState = displayPkg::stGraph;
			displayPkg::stGraph:
				if (barLast)
					nextState = displayPkg::stIdle;
			default:
				nextState = displayPkg::stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetn)
			state <= displayPkg::stIdle;
		else
			state <= nextState;
	end

	// run levels straight from the state
	assign runClear = (state == displayPkg::stClear);
	assign runGraph = (state == displayPkg::stGraph);

	// reported state moves with the registered pixel,
	// so it reads idle once the last bar pixel has left
	always_ff @(posedge clk) begin
		if (resetn) begin
			plot <= 1'b0;
			currentState <= displayPkg::stIdle;
		end else begin
			plot <= (runClear && clearValid) || (runGraph && barValid);
			currentState <= state;
		end
	end

	// pixel payload
	always_ff @(posedge clk) begin
		if (runClear) begin
			x <= clearX;
			y <= clearY;
			colour <= displayPkg::colBlack;
		end else begin
			x <= barX;
			y <= barY;
			colour <= barColour;
		end
	end

endmodule

//--- rtl/levelBank.sv
// level register file, one entry per note, written from outside and read by the bar plotter
`timescale 1ns/1ps

module levelBank (
	input logic clk,
	input logic resetn,
	input logic levelWe,
	input notePkg::noteT levelNote,
	input notePkg::noteT readNote,
	input notePkg::levelT levelValue,
	output notePkg::levelT readLevel
);

	notePkg::levelT levels [notePkg::noteCount];

	always_ff @(posedge clk) begin
		if (resetn) begin
			for (int i = 0; i < notePkg::noteCount; i++)
				levels[i] <= '0;
		end else if (levelWe && (levelNote <= notePkg::noteA5)) begin
			// codes past A5 have no entry, drop them
			levels[levelNote] <= levelValue;
		end
	end

	// async read port
	// out of range reads give zero
	assign readLevel = (readNote <= notePkg::noteA5) ? levels[readNote] : '0;

endmodule

//--- rtl/notePkg.sv
// note codes, level format and bar layout for the thirteen-note bar graph
package notePkg;

	// one semitone per bar, A4 up to A5
	typedef enum logic [3:0] {
		noteA4,
		noteAs4,
		noteB4,
		noteC5,
		noteCs5,
		noteD5,
		noteDs5,
		noteE5,
		noteF5,
		noteFs5,
		noteG5,
		noteGs5,
		noteA5
	} noteT;

	localparam int noteCount = 13;

	// [11:8] overflow nibble, [7:0] magnitude
	typedef logic [11:0] levelT;

	// bar layout on screen
	localparam int barBaseX = 4;
	localparam int barPitch = 19;
	localparam int barWidth = 11;
	// bottom row shared by all bars
	localparam int barBottom = 219;
	// a zero magnitude puts the top here
	localparam int barFloor = 216;
	// full bar top, also the clamp for tall bars
	localparam int fullBarTop = 4;

endpackage

//--- rtl/refreshTimer.sv
// refresh timer, divides the clock into ticks and pulses frameStart once per frame period
`timescale 1ns/1ps

module refreshTimer #(
	parameter int tickDivide = 833334,
	parameter int ticksPerFrame = 30
) (
	input logic clk,
	input logic resetn,
	output logic frameStart
);

	// counter widths, at least one bit each
	localparam int tickW = $clog2(tickDivide > 1 ? tickDivide : 2);
	localparam int frameW = $clog2(ticksPerFrame > 1 ? ticksPerFrame : 2);

	logic [tickW-1:0] tickCnt;
	logic [frameW-1:0] frameCnt;
	logic tick;

	// tick when the divider runs out
	assign tick = (tickCnt == '0);

	always_ff @(posedge clk) begin
		if (resetn) begin
			tickCnt <= '0;
			frameCnt <= '0;
		end else begin
			// divider reload on underflow
			if (tick)
				tickCnt <= tickW'(tickDivide - 1);
			else
				tickCnt <= tickCnt - 1'b1;
			// frame count only moves on ticks
			if (tick) begin
				if (frameCnt == '0)
					frameCnt <= frameW'(ticksPerFrame - 1);
				else
					frameCnt <= frameCnt - 1'b1;
			end
		end
	end

	// both at zero, one cycle per frame period
	assign frameStart = tick && (frameCnt == '0);

endmodule

//--- rtl/screenClear.sv
// screen clear datapath, gives every screen coordinate once in raster order while enabled
`timescale 1ns/1ps

module screenClear (
	input logic clk,
	input logic resetn,
	input logic runClear,
	output logic clearValid,
	output logic clearLast,
	output displayPkg::xCoord clearX,
	output displayPkg::yCoord clearY
);

	localparam displayPkg::xCoord lastX = displayPkg::xCoord'(displayPkg::screenWidth - 1);
	localparam displayPkg::yCoord lastY = displayPkg::yCoord'(displayPkg::screenHeight - 1);

	logic endOfRow;

	assign endOfRow = (clearX == lastX);

	// column runs fastest, row steps at end of each line
	always_ff @(posedge clk) begin
		if (resetn) begin
			clearX <= '0;
			clearY <= '0;
		end else if (runClear) begin
			if (endOfRow) begin
				clearX <= '0;
				// wrap to origin after the final pixel
				if (clearY == lastY)
					clearY <= '0;
				else
					clearY <= clearY + 1'b1;
			end else begin
				clearX <= clearX + 1'b1;
			end
		end
	end

	// one pixel every enabled cycle
	assign clearValid = runClear;
	// flagged with the bottom right pixel
	assign clearLast = runClear && endOfRow && (clearY == lastY);

endmodule

//--- rtl/spectrumDisplay.sv
// top level of the note bar graph, timer, level bank, clear and bar datapaths under frame control
`timescale 1ns/1ps

module spectrumDisplay #(
	parameter int tickDivide = 833334,
	parameter int ticksPerFrame = 30
) (
	input logic clk,
	input logic resetn,
	input logic levelWe,
	input notePkg::noteT levelNote,
	input notePkg::levelT levelValue,
	output logic plot,
	output displayPkg::xCoord x,
	output displayPkg::yCoord y,
	output displayPkg::colourT colour,
	output displayPkg::frameState currentState
);

	logic frameStart;
	logic runClear;
	logic runGraph;
	// clear datapath
	logic clearValid;
	logic clearLast;
	displayPkg::xCoord clearX;
	displayPkg::yCoord clearY;
	// bar datapath
	logic barValid;
	logic barLast;
	displayPkg::xCoord barX;
	displayPkg::yCoord barY;
	displayPkg::colourT barColour;
	// level read port
	notePkg::noteT readNote;
	notePkg::levelT readLevel;

	refreshTimer #(
		.tickDivide(tickDivide),
		.ticksPerFrame(ticksPerFrame)
	) timer (
		.clk(clk),
		.resetn(resetn),
		.frameStart(frameStart)
	);

	levelBank bank (
		.clk(clk),
		.resetn(resetn),
		.levelWe(levelWe),
		.levelNote(levelNote),
		.readNote(readNote),
		.levelValue(levelValue),
		.readLevel(readLevel)
	);

	screenClear clearPath (
		.clk(clk),
		.resetn(resetn),
		.runClear(runClear),
		.clearValid(clearValid),
		.clearLast(clearLast),
		.clearX(clearX),
		.clearY(clearY)
	);

	barPlotter barPath (
		.clk(clk),
		.resetn(resetn),
		.runGraph(runGraph),
		.readLevel(readLevel),
		.readNote(readNote),
		.barValid(barValid),
		.barLast(barLast),
		.barX(barX),
		.barY(barY),
		.barColour(barColour)
	);

	frameControl ctrl (
		.clk(clk),
		.resetn(resetn),
		.frameStart(frameStart),
		.clearValid(clearValid),
		.clearLast(clearLast),
		.barValid(barValid),
		.barLast(barLast),
		.clearX(clearX),
		.barX(barX),
		.clearY(clearY),
		.barY(barY),
		.barColour(barColour),
		.runClear(runClear),
		.runGraph(runGraph),
		.plot(plot),
		.x(x),
		.y(y),
		.colour(colour),
		.currentState(currentState)
	);

endmodule

//--- vlog.f
rtl/displayPkg.sv
rtl/notePkg.sv
rtl/refreshTimer.sv
rtl/levelBank.sv
rtl/screenClear.sv
rtl/barPlotter.sv
rtl/frameControl.sv
rtl/spectrumDisplay.sv
dv/spectrumDisplay_asserts.sv
dv/spectrumDisplay_tb.sv
